//--- verilog/cpu_macros.svh
//////////////////////////////
// core-wide constants and opcode field values
// include wherever widths, the reset PC or opcode
// matching are needed
//////////////////////////////
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN      32
`define CPU_REG_COUNT 32
`define CPU_RESET_PC  32'h1c00_0000
`define CPU_PC_STEP   32'd4

// primary field, bits 31..26
`define OP6_ALU   6'h00
`define OP6_LU12I 6'h05
`define OP6_MEM   6'h0a
`define OP6_B     6'h14
`define OP6_BEQ   6'h16
`define OP6_BNE   6'h17

// bits 25..22
`define OP4_REG3  4'h0
`define OP4_ADDI  4'ha
`define OP4_ANDI  4'hd
`define OP4_ORI   4'he
`define OP4_LD_W  4'h2
`define OP4_ST_W  4'h6

// bits 21..20 and 19..15, three-register group
`define OP2_REG3  2'h1
`define OP5_ADD_W 5'h00
`define OP5_SUB_W 5'h02
`define OP5_AND   5'h09
`define OP5_OR    5'h0a
`define OP5_XOR   5'h0b

`endif

//--- verilog/isa_pkg.sv
//////////////////////////////
// instruction-set level types
// shared by the decoder, execute and the pipeline structs
//////////////////////////////
`include "cpu_macros.svh"

package isa_pkg;

    // one machine word
    typedef logic [`CPU_XLEN-1:0] word_t;

    // architectural register number
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

    // ALU functions, lui passes operand 2 through
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_t;

    // branch condition checked in execute
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_EQ     = 2'd1,
        BR_NE     = 2'd2,
        BR_ALWAYS = 2'd3
    } br_kind_t;

endpackage

//--- verilog/pipe_pkg.sv
//////////////////////////////
// pipeline payloads and outside port structs
// one struct per pipeline register, plus data memory and trace
//////////////////////////////
package pipe_pkg;
    import isa_pkg::*;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rj_val;
        word_t    rk_val;
        reg_idx_t rj;
        reg_idx_t rk;
        word_t    imm;
        alu_op_t  alu_op;
        logic     src2_is_imm;
        br_kind_t br_kind;
        word_t    br_offs;
        logic     mem_we;
        logic     res_from_mem;
        logic     gr_we;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    alu_res;
        word_t    st_data;
        reg_idx_t dest;
        logic     gr_we;
        logic     mem_we;
        logic     res_from_mem;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t dest;
        logic     gr_we;
        word_t    value;
    } mem_wb_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF     = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    // write-back trace, one entry per register write
    typedef struct packed {
        logic     we;
        word_t    pc;
        reg_idx_t rnum;
        word_t    wdata;
    } wb_trace_t;

endpackage

//--- verilog/stage_reg.sv
//////////////////////////////
// generic pipeline register
// flush or reset inserts a bubble, hold freezes the stage
//////////////////////////////
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload has valid low
    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- verilog/regfile.sv
//////////////////////////////
// 32 x 32 register file, two read ports and one write port
// a read of the register being written sees the new value
//////////////////////////////
`timescale 1ns/1ps

module regfile import isa_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [2**$bits(reg_idx_t)];

    // r0 reads zero, same-cycle write passes through
    function automatic word_t read_port(reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

    // write-back is drained while the pipe is in reset
    no_write_in_reset: assert property (@(posedge clk) !resetn |-> !we);

endmodule

//--- verilog/inst_decoder.sv
//////////////////////////////
// decode stage logic
// turns the IF/ID word into execute controls and source numbers,
// unused sources come out as r0 so they never stall or forward
//////////////////////////////
`timescale 1ns/1ps
`include "cpu_macros.svh"

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  if_id_t   if_id,
    output reg_idx_t rj,
    output reg_idx_t rk_or_rd,
    output id_ex_t   dec
);

    word_t inst;
    logic  is_reg3;
    logic  i_add, i_sub, i_and, i_or, i_xor;
    logic  i_addi, i_andi, i_ori, i_lu12i;
    logic  i_ld, i_st, i_b, i_beq, i_bne;
    logic  known;
    logic  src_is_rd;
    logic  uses_rj;
    logic  uses_rk;

    assign inst    = if_id.inst;
    assign is_reg3 = inst[31:26] == `OP6_ALU && inst[25:22] == `OP4_REG3
                     && inst[21:20] == `OP2_REG3;

    assign i_add   = is_reg3 && inst[19:15] == `OP5_ADD_W;
    assign i_sub   = is_reg3 && inst[19:15] == `OP5_SUB_W;
    assign i_and   = is_reg3 && inst[19:15] == `OP5_AND;
    assign i_or    = is_reg3 && inst[19:15] == `OP5_OR;
    assign i_xor   = is_reg3 && inst[19:15] == `OP5_XOR;
    assign i_addi  = inst[31:26] == `OP6_ALU && inst[25:22] == `OP4_ADDI;
    assign i_andi  = inst[31:26] == `OP6_ALU && inst[25:22] == `OP4_ANDI;
    assign i_ori   = inst[31:26] == `OP6_ALU && inst[25:22] == `OP4_ORI;
    assign i_lu12i = inst[31:26] == `OP6_LU12I && !inst[25];
    assign i_ld    = inst[31:26] == `OP6_MEM && inst[25:22] == `OP4_LD_W;
    assign i_st    = inst[31:26] == `OP6_MEM && inst[25:22] == `OP4_ST_W;
    assign i_b     = inst[31:26] == `OP6_B;
    assign i_beq   = inst[31:26] == `OP6_BEQ;
    assign i_bne   = inst[31:26] == `OP6_BNE;

    assign known = if_id.valid && (i_add || i_sub || i_and || i_or || i_xor || i_addi
                   || i_andi || i_ori || i_lu12i || i_ld || i_st || i_b || i_beq || i_bne);

    // stores and compare branches take rd as the second source
    assign src_is_rd = i_st || i_beq || i_bne;
    assign uses_rj   = !(i_lu12i || i_b);
    assign uses_rk   = is_reg3 || src_is_rd;

    assign rj       = (known && uses_rj) ? inst[9:5] : '0;
    assign rk_or_rd = !(known && uses_rk) ? '0 : src_is_rd ? inst[4:0] : inst[14:10];

    always_comb begin
        dec    = '0;
        dec.pc = if_id.pc;
        if (known) begin
            dec.valid = 1'b1;
            dec.rj    = rj;
            dec.rk    = rk_or_rd;
            if (i_sub)              dec.alu_op = ALU_SUB;
            else if (i_and || i_andi) dec.alu_op = ALU_AND;
            else if (i_or || i_ori)   dec.alu_op = ALU_OR;
            else if (i_xor)           dec.alu_op = ALU_XOR;
            else if (i_lu12i)         dec.alu_op = ALU_LUI;
            else                      dec.alu_op = ALU_ADD;
            dec.src2_is_imm = i_addi || i_andi || i_ori || i_lu12i || i_ld || i_st;
            // lu12i upper immediate, logical ops zero extend, the rest sign extend
            if (i_lu12i)             dec.imm = {inst[24:5], 12'b0};
            else if (i_andi || i_ori) dec.imm = {20'b0, inst[21:10]};
            else                      dec.imm = {{20{inst[21]}}, inst[21:10]};
            if (i_beq)      dec.br_kind = BR_EQ;
            else if (i_bne) dec.br_kind = BR_NE;
            else if (i_b)   dec.br_kind = BR_ALWAYS;
            else            dec.br_kind = BR_NONE;
            // offs26 is split, low half sits in bits 9..0
            dec.br_offs = i_b ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                              : {{14{inst[25]}}, inst[25:10], 2'b00};
            dec.mem_we       = i_st;
            dec.res_from_mem = i_ld;
            dec.gr_we        = !(i_st || i_b || i_beq || i_bne);
            dec.dest         = dec.gr_we ? inst[4:0] : '0;
        end
    end

endmodule

//--- verilog/execute_unit.sv
//////////////////////////////
// execute stage logic
// picks forwarded operands, runs the ALU and resolves branches
//////////////////////////////
`timescale 1ns/1ps

module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    ex_mem_fwd,
    input  word_t    mem_wb_fwd,
    output ex_mem_t  ex_mem,
    output logic     branch_taken,
    output word_t    branch_target
);

    word_t src_a;
    word_t src_b;
    word_t opnd2;
    word_t alu_res;

    function automatic word_t pick(fwd_sel_t sel, word_t rf_val, word_t em_val, word_t mw_val);
        case (sel)
            FWD_EX_MEM: return em_val;
            FWD_MEM_WB: return mw_val;
            default:    return rf_val;
        endcase
    endfunction

    assign src_a = pick(fwd_a, id_ex.rj_val, ex_mem_fwd, mem_wb_fwd);
    assign src_b = pick(fwd_b, id_ex.rk_val, ex_mem_fwd, mem_wb_fwd);
    assign opnd2 = id_ex.src2_is_imm ? id_ex.imm : src_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_res = src_a - opnd2;
            ALU_AND: alu_res = src_a & opnd2;
            ALU_OR:  alu_res = src_a | opnd2;
            ALU_XOR: alu_res = src_a ^ opnd2;
            ALU_LUI: alu_res = opnd2;
            default: alu_res = src_a + opnd2;
        endcase
    end

    // branch compare uses the two register sources
    assign branch_taken  = id_ex.valid && ((id_ex.br_kind == BR_EQ && src_a == src_b)
                           || (id_ex.br_kind == BR_NE && src_a != src_b)
                           || id_ex.br_kind == BR_ALWAYS);
    assign branch_target = id_ex.pc + id_ex.br_offs;

    assign ex_mem = '{valid: id_ex.valid, pc: id_ex.pc, alu_res: alu_res, st_data: src_b,
                      dest: id_ex.dest, gr_we: id_ex.gr_we, mem_we: id_ex.mem_we,
                      res_from_mem: id_ex.res_from_mem};

endmodule

//--- verilog/mem_stage.sv
//////////////////////////////
// memory stage and write-back register
// issues the data request, picks the result and drives the trace
//////////////////////////////
`timescale 1ns/1ps

module mem_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  ex_mem_t   ex_mem,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output mem_wb_t   mem_wb,
    output wb_trace_t wb_trace
);

    mem_wb_t mem_wb_d;

    assign dmem_req = '{we: ex_mem.valid && ex_mem.mem_we, addr: ex_mem.alu_res,
                        wdata: ex_mem.st_data};

    // loads return the memory word, everything else the ALU result
    assign mem_wb_d = '{valid: ex_mem.valid, pc: ex_mem.pc, dest: ex_mem.dest,
                        gr_we: ex_mem.gr_we,
                        value: ex_mem.res_from_mem ? dmem_rdata : ex_mem.alu_res};

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk    (clk),
        .resetn (resetn),
        .hold   (1'b0),
        .flush  (1'b0),
        .d      (mem_wb_d),
        .q      (mem_wb)
    );

    assign wb_trace = '{we: mem_wb.valid && mem_wb.gr_we, pc: mem_wb.pc,
                        rnum: mem_wb.dest, wdata: mem_wb.value};

endmodule

//--- verilog/pipe_ctrl.sv
//////////////////////////////
// pipeline control
// owns the fetch PC and decides stall, flush and the
// execute forwarding selects each cycle
//////////////////////////////
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pipe_ctrl import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    output word_t    pc,
    output logic     if_id_hold,
    output logic     if_id_flush,
    output logic     id_ex_flush,
    input  reg_idx_t dec_rj,
    input  reg_idx_t dec_rk,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    input  logic     branch_taken,
    input  word_t    branch_target,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    logic  load_in_ex;
    logic  stall;
    word_t next_pc;

    // loads in EX/MEM have no data yet, MEM/WB covers them
    function automatic fwd_sel_t pick_src(reg_idx_t r, ex_mem_t em, mem_wb_t mw);
        if (r != '0 && em.valid && em.gr_we && !em.res_from_mem && em.dest == r) begin
            return FWD_EX_MEM;
        end
        if (r != '0 && mw.valid && mw.gr_we && mw.dest == r) begin
            return FWD_MEM_WB;
        end
        return FWD_RF;
    endfunction

    //////////////////////////////
    // load-use stall and flushes
    //////////////////////////////
    assign load_in_ex = id_ex.valid && id_ex.res_from_mem && id_ex.dest != '0;
    assign stall      = load_in_ex && (id_ex.dest == dec_rj || id_ex.dest == dec_rk);

    assign if_id_hold  = stall;
    assign if_id_flush = branch_taken;
    assign id_ex_flush = stall || branch_taken;

    //////////////////////////////
    // fetch PC
    //////////////////////////////
    assign next_pc = branch_taken ? branch_target : stall ? pc : pc + `CPU_PC_STEP;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `CPU_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign fwd_a = pick_src(id_ex.rj, ex_mem, mem_wb);
    assign fwd_b = pick_src(id_ex.rk, ex_mem, mem_wb);

    // branch offsets from decode keep fetch word aligned
    pc_aligned: assert property (@(posedge clk) disable iff (!resetn) pc[1:0] == 2'b00);

    // a load in execute can never be a taken branch
    no_stall_on_branch: assert property (@(posedge clk) disable iff (!resetn)
        !(stall && branch_taken));

endmodule

//--- verilog/cpu_core.sv
//////////////////////////////
// five-stage core top level
// connects control, stages and pipeline registers to the
// instruction port, the data port and the write-back trace
//////////////////////////////
`timescale 1ns/1ps

module cpu_core import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    output word_t     inst_addr,
    input  word_t     inst_rdata,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output wb_trace_t wb_trace
);

    logic     if_id_hold, if_id_flush, id_ex_flush;
    logic     branch_taken;
    word_t    branch_target;
    fwd_sel_t fwd_a, fwd_b;
    reg_idx_t dec_rj, dec_rk;
    word_t    rf_rdata1, rf_rdata2;
    if_id_t   if_id_d, if_id_q;
    id_ex_t   dec, id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb;

    assign if_id_d = '{valid: 1'b1, pc: inst_addr, inst: inst_rdata};

    // decoded fields plus register read values
    always_comb begin
        id_ex_d        = dec;
        id_ex_d.rj_val = rf_rdata1;
        id_ex_d.rk_val = rf_rdata2;
    end

    pipe_ctrl u_ctrl (
        .clk (clk), .resetn (resetn), .pc (inst_addr),
        .if_id_hold (if_id_hold), .if_id_flush (if_id_flush), .id_ex_flush (id_ex_flush),
        .dec_rj (dec_rj), .dec_rk (dec_rk), .id_ex (id_ex_q), .ex_mem (ex_mem_q),
        .mem_wb (mem_wb), .branch_taken (branch_taken), .branch_target (branch_target),
        .fwd_a (fwd_a), .fwd_b (fwd_b)
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk (clk), .resetn (resetn), .hold (if_id_hold), .flush (if_id_flush),
        .d (if_id_d), .q (if_id_q)
    );

    inst_decoder u_dec (.if_id (if_id_q), .rj (dec_rj), .rk_or_rd (dec_rk), .dec (dec));

    // write port is fed straight from the trace
    regfile u_rf (
        .clk (clk), .resetn (resetn), .raddr1 (dec_rj), .raddr2 (dec_rk),
        .rdata1 (rf_rdata1), .rdata2 (rf_rdata2),
        .we (wb_trace.we), .waddr (wb_trace.rnum), .wdata (wb_trace.wdata)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk (clk), .resetn (resetn), .hold (1'b0), .flush (id_ex_flush),
        .d (id_ex_d), .q (id_ex_q)
    );

    execute_unit u_ex (
        .id_ex (id_ex_q), .fwd_a (fwd_a), .fwd_b (fwd_b),
        .ex_mem_fwd (ex_mem_q.alu_res), .mem_wb_fwd (mem_wb.value),
        .ex_mem (ex_mem_d), .branch_taken (branch_taken), .branch_target (branch_target)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk (clk), .resetn (resetn), .hold (1'b0), .flush (1'b0),
        .d (ex_mem_d), .q (ex_mem_q)
    );

    mem_stage u_mem (
        .clk (clk), .resetn (resetn), .ex_mem (ex_mem_q), .dmem_req (dmem_req),
        .dmem_rdata (dmem_rdata), .mem_wb (mem_wb), .wb_trace (wb_trace)
    );

endmodule

//--- tb/tb_clock.sv
//////////////////////////////
// clock and reset source for the core testbench
// resetn is released on a falling edge after RESET_CYCLES
//////////////////////////////
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- tb/cpu_core_tb.sv
//////////////////////////////
// testbench for the five-stage core
// loads a fixed program, then checks every write-back
// trace entry against a table built from the ISA rules
//////////////////////////////
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam int MEM_WORDS  = 64;
    localparam int CLK_PERIOD = 40;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rnum;
        word_t    wdata;
    } trace_exp_t;

    logic       clk;
    logic       resetn;
    word_t      inst_addr;
    word_t      inst_rdata;
    word_t      inst_offs;
    dmem_req_t  dmem_req;
    word_t      dmem_rdata;
    wb_trace_t  wb_trace;

    word_t      imem [MEM_WORDS];
    word_t      dmem [MEM_WORDS];
    trace_exp_t exp_q [$];
    int         prog_len;
    word_t      seed_a;
    word_t      seed_b;
    logic       in_reset;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clk_gen (.clk(clk), .resetn(resetn));

    cpu_core dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb_trace   (wb_trace)
    );

    // words past the program read as zero and decode as bubbles
    assign inst_offs  = inst_addr - `CPU_RESET_PC;
    assign inst_rdata = (inst_offs < MEM_WORDS * 4) ? imem[inst_offs[7:2]] : '0;

    // data memory reads combinationally and writes on the rising edge
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    //////////////////////////////
    // instruction encoders
    //////////////////////////////
    function automatic word_t reg3_word(logic [4:0] op5, int rd, int rj, int rk);
        return {`OP6_ALU, `OP4_REG3, `OP2_REG3, op5, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t imm12_word(logic [5:0] op6, logic [3:0] op4, int rd, int rj,
                                         logic [11:0] imm);
        return {op6, op4, imm, 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t lu12i_word(int rd, logic [19:0] imm);
        return {`OP6_LU12I, 1'b0, imm, 5'(rd)};
    endfunction

    // offsets are in words, relative to the branch itself
    function automatic word_t cond_branch_word(logic [5:0] op6, int rj, int rd, int offs);
        return {op6, 16'(offs), 5'(rj), 5'(rd)};
    endfunction

    function automatic word_t jump_word(int offs);
        logic [25:0] offs26;
        offs26 = 26'(offs);
        return {`OP6_B, offs26[15:0], offs26[25:16]};
    endfunction

    task automatic place_inst(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // expected write of the instruction placed last
    task automatic add_expected(int rnum, word_t value);
        trace_exp_t e;
        e.pc    = `CPU_RESET_PC + `CPU_PC_STEP * word_t'(prog_len - 1);
        e.rnum  = 5'(rnum);
        e.wdata = value;
        exp_q.push_back(e);
    endtask

    task automatic compare_value(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic build_program();
        prog_len = 0;
        // immediates, negative addi and zero-extended logic ops
        place_inst(lu12i_word(1, 20'h12345));
        add_expected(1, 32'h1234_5000);
        place_inst(imm12_word(`OP6_ALU, `OP4_ORI, 1, 1, 12'h678));
        add_expected(1, 32'h1234_5678);
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 2, 0, 12'hffb));
        add_expected(2, 32'hffff_fffb);
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 3, 0, 12'h7ff));
        add_expected(3, 32'h0000_07ff);
        place_inst(imm12_word(`OP6_ALU, `OP4_ANDI, 4, 2, 12'hf0f));
        add_expected(4, 32'h0000_0f0b);
        place_inst(imm12_word(`OP6_ALU, `OP4_ORI, 5, 0, 12'h800));
        add_expected(5, 32'h0000_0800);
        // register ops at several forwarding distances
        place_inst(reg3_word(`OP5_ADD_W, 6, 1, 3));
        add_expected(6, 32'h1234_5e77);
        place_inst(reg3_word(`OP5_SUB_W, 7, 6, 2));
        add_expected(7, 32'h1234_5e7c);
        place_inst(reg3_word(`OP5_AND, 8, 7, 2));
        add_expected(8, 32'h1234_5e78);
        place_inst(reg3_word(`OP5_OR, 9, 3, 5));
        add_expected(9, 32'h0000_0fff);
        place_inst(reg3_word(`OP5_XOR, 10, 1, 2));
        add_expected(10, 32'hedcb_a983);
        // r0 written, then read back as zero
        place_inst(reg3_word(`OP5_ADD_W, 0, 1, 1));
        add_expected(0, 32'h2468_acf0);
        place_inst(reg3_word(`OP5_ADD_W, 11, 0, 3));
        add_expected(11, 32'h0000_07ff);
        place_inst(reg3_word(`OP5_OR, 12, 0, 0));
        add_expected(12, 32'h0000_0000);
        //////////////////////////////
        // loads and stores
        //////////////////////////////
        place_inst(imm12_word(`OP6_MEM, `OP4_ST_W, 10, 0, 12'h020));
        place_inst(imm12_word(`OP6_MEM, `OP4_LD_W, 13, 0, 12'h020));
        add_expected(13, 32'hedcb_a983);
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 14, 13, 12'h001));
        add_expected(14, 32'hedcb_a984);
        place_inst(imm12_word(`OP6_MEM, `OP4_LD_W, 15, 0, 12'h010));
        add_expected(15, seed_a);
        place_inst(imm12_word(`OP6_MEM, `OP4_LD_W, 16, 0, 12'h014));
        add_expected(16, seed_b);
        place_inst(reg3_word(`OP5_XOR, 17, 15, 16));
        add_expected(17, seed_a ^ seed_b);
        place_inst(imm12_word(`OP6_MEM, `OP4_ST_W, 17, 0, 12'h024));
        place_inst(imm12_word(`OP6_MEM, `OP4_LD_W, 18, 0, 12'h024));
        add_expected(18, seed_a ^ seed_b);
        //////////////////////////////
        // branches
        //////////////////////////////
        // taken ones skip the next two words
        place_inst(cond_branch_word(`OP6_BEQ, 1, 1, 3));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 20, 0, 12'h001));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 20, 0, 12'h002));
        place_inst(cond_branch_word(`OP6_BNE, 1, 2, 3));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 21, 0, 12'h001));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 21, 0, 12'h002));
        place_inst(jump_word(3));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 22, 0, 12'h001));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 22, 0, 12'h002));
        // untaken ones fall through
        place_inst(cond_branch_word(`OP6_BEQ, 1, 2, 3));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 23, 0, 12'h123));
        add_expected(23, 32'h0000_0123);
        place_inst(cond_branch_word(`OP6_BNE, 11, 3, 3));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 24, 23, 12'h010));
        add_expected(24, 32'h0000_0133);
        // compare operand forwarded from the previous instruction
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 25, 0, 12'h007));
        add_expected(25, 32'h0000_0007);
        place_inst(cond_branch_word(`OP6_BNE, 25, 0, 3));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 26, 0, 12'h001));
        place_inst(imm12_word(`OP6_ALU, `OP4_ADDI, 26, 0, 12'h002));
        place_inst(reg3_word(`OP5_ADD_W, 26, 25, 24));
        add_expected(26, 32'h0000_013a);
    endtask

    initial begin
        void'($urandom(32'hef08));
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        foreach (dmem[i]) begin
            dmem[i] = '0;
        end
        seed_a  = $urandom();
        seed_b  = $urandom();
        dmem[4] = seed_a;
        dmem[5] = seed_b;
        build_program();

        // nothing retires or stores while reset is held
        // fetch sits at the reset PC until release
        do begin
            @(posedge clk);
            in_reset = !resetn;
            @(negedge clk);
            compare_value("wb_trace.we", 32'd0, 32'(wb_trace.we));
            compare_value("dmem_req.we", 32'd0, 32'(dmem_req.we));
            if (in_reset) begin
                compare_value("inst_addr", `CPU_RESET_PC, inst_addr);
            end
        end while (in_reset);

        foreach (exp_q[i]) begin
            do begin
                @(negedge clk);
            end while (!wb_trace.we);
            compare_value("wb_trace.pc", exp_q[i].pc, wb_trace.pc);
            compare_value("wb_trace.rnum", 32'(exp_q[i].rnum), 32'(wb_trace.rnum));
            compare_value("wb_trace.wdata", exp_q[i].wdata, wb_trace.wdata);
        end

        // no stray writes once the program has drained
        repeat (8) begin
            @(negedge clk);
            compare_value("wb_trace.we", 32'd0, 32'(wb_trace.we));
        end
        compare_value("dmem[8]", 32'hedcb_a983, dmem[8]);
        compare_value("dmem[9]", seed_a ^ seed_b, dmem[9]);
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog allows eight cycles per program word
    initial begin
        wait (resetn);
        repeat (prog_len * 8) @(posedge clk);
        $display("trace never finished within %0d cycles", prog_len * 8);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- build.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/regfile.sv
verilog/inst_decoder.sv
verilog/execute_unit.sv
verilog/mem_stage.sv
verilog/pipe_ctrl.sv
verilog/cpu_core.sv
tb/tb_clock.sv
tb/cpu_core_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpu_core_tb -f build.f -o sim &&
./obj_dir/sim | tee /dev/stderr | grep -qx "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
